// ==== program.hex ====
// One instruction word per line from address 0
// Columns: hex word, then byte address and assembly
00500093  // 00 addi x1, x0, 5
FFD08113  // 04 addi x2, x1, -3
800001B7  // 08 lui x3, 0x80000
00208233  // 0C add x4, x1, x2
404102B3  // 10 sub x5, x2, x4
00209333  // 14 sll x6, x1, x2
4021D3B3  // 18 sra x7, x3, x2
0041D413  // 1C srli x8, x3, 4
0012A4B3  // 20 slt x9, x5, x1
0012B533  // 24 sltu x10, x5, x1
0040C5B3  // 28 xor x11, x1, x4
0022E633  // 2C or x12, x5, x2
0012F6B3  // 30 and x13, x5, x1
00001717  // 34 auipc x14, 0x1
04502023  // 38 sw x5, 64(x0)
04002783  // 3C lw x15, 64(x0)
00178813  // 40 addi x16, x15, 1
00208863  // 44 beq x1, x2, +16 (not taken)
01100893  // 48 addi x17, x0, 17
00209663  // 4C bne x1, x2, +12 (taken)
00100913  // 50 addi x18, x0, 1 (skipped)
00200913  // 54 addi x18, x0, 2 (skipped)
00C009EF  // 58 jal x19, +12
00100A13  // 5C addi x20, x0, 1 (skipped)
00200A13  // 60 addi x20, x0, 2 (skipped)
01098AE7  // 64 jalr x21, 16(x19)
00100B13  // 68 addi x22, x0, 1 (skipped)
000A8B93  // 6C addi x23, x21, 0
0000006F  // 70 jal x0, 0

// ==== filelist.f ====
rv32i_pkg.sv
rv32i_fetch.sv
rv32i_decode.sv
rv32i_execute.sv
rv32i_memory.sv
rv32i_core.sv
tb_rv32i_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the RV32I core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_rv32i_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv32i_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tb_rv32i_core.sv ====
`timescale 1ns/1ps
//----------------------------------------------------------------------------
// RV32I core testbench
// Runs the test program under random freeze bursts and checks each
// register write on the retire port against a hand-derived list
//----------------------------------------------------------------------------
module tb_rv32i_core
    import rv32i_pkg::*;
();

    localparam int CLK_HALF           = 2;
    localparam int RESET_CYCLES       = 10;
    localparam int DRIVE_DELAY        = 1;
    localparam int FIRST_RETIRE_CYCLE = 4;
    localparam int PROG_WORDS         = 29;
    // Room for a five-cycle freeze ahead of every instruction
    localparam int STALL_BUDGET       = 6 * PROG_WORDS;
    localparam int WATCHDOG_CYCLES    = 10 * (PROG_WORDS + STALL_BUDGET);
    localparam int DRAIN_CYCLES       = 20;

    logic    clk_i;
    logic    rst_i;
    logic    stall_i;
    retire_t retire;

    logic [REG_ADDR_W-1:0] exp_rd   [64];
    logic [XLEN-1:0]       exp_data [64];
    logic [5:0]            exp_count;
    logic [5:0]            exp_idx;
    logic                  stall_q;
    int                    cycles_after_rst;
    int                    checks = 0;
    int                    errors = 0;

    rv32i_core rv32i_core_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .retire_o (retire)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    // Bookkeeping moves on the rising edge, checks sample on the falling one
    always @(posedge clk_i) begin
        if (rst_i) begin
            exp_idx          <= '0;
            stall_q          <= 1'b0;
            cycles_after_rst <= 0;
        end else begin
            stall_q <= stall_i;
            if (cycles_after_rst < WATCHDOG_CYCLES) begin
                cycles_after_rst <= cycles_after_rst + 1;
            end
            if (retire.we && retire.rd != '0) begin
                exp_idx <= exp_idx + 6'd1;
                checks  <= checks + 1;
            end
        end
    end

    assert property (@(negedge clk_i) disable iff (rst_i)
                     (retire.we && retire.rd != '0) |->
                     (exp_idx < exp_count && retire.rd == exp_rd[exp_idx] &&
                      retire.data == exp_data[exp_idx]))
        else begin
            errors++;
            $display("CHECK FAILED at %0t ns: write %0d is x%0d = %h, expected x%0d = %h",
                     $time, exp_idx, retire.rd, retire.data, exp_rd[exp_idx],
                     exp_data[exp_idx]);
        end

    // MEM/WB takes a bubble on every frozen edge
    assert property (@(negedge clk_i) disable iff (rst_i) stall_q |-> !retire.we)
        else begin
            errors++;
            $display("CHECK FAILED at %0t ns: write to x%0d retired during a freeze",
                     $time, retire.rd);
        end

    assert property (@(negedge clk_i)
                     (rst_i || cycles_after_rst < FIRST_RETIRE_CYCLE) |-> !retire.we)
        else begin
            errors++;
            $display("CHECK FAILED at %0t ns: write enable high %0d cycles after reset",
                     $time, cycles_after_rst);
        end

    task automatic add_expected(input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] data);
        exp_rd[exp_count]   = rd;
        exp_data[exp_count] = data;
        exp_count           = exp_count + 6'd1;
    endtask

    // Register writes of the test program in program order
    task automatic load_expected();
        add_expected(5'd1,  32'h0000_0005);
        add_expected(5'd2,  32'h0000_0002);
        add_expected(5'd3,  32'h8000_0000);
        add_expected(5'd4,  32'h0000_0007);
        add_expected(5'd5,  32'hFFFF_FFFB);
        add_expected(5'd6,  32'h0000_0014);
        add_expected(5'd7,  32'hE000_0000);
        add_expected(5'd8,  32'h0800_0000);
        add_expected(5'd9,  32'h0000_0001);
        add_expected(5'd10, 32'h0000_0000);
        add_expected(5'd11, 32'h0000_0002);
        add_expected(5'd12, 32'hFFFF_FFFB);
        add_expected(5'd13, 32'h0000_0001);
        add_expected(5'd14, 32'h0000_1034);
        // Load of the stored word, then its use across the interlock
        add_expected(5'd15, 32'hFFFF_FFFB);
        add_expected(5'd16, 32'hFFFF_FFFC);
        add_expected(5'd17, 32'h0000_0011);
        // Link values of jal and jalr, then a read of the jalr link
        add_expected(5'd19, 32'h0000_005C);
        add_expected(5'd21, 32'h0000_0068);
        add_expected(5'd23, 32'h0000_0068);
    endtask

    // Freeze bursts of 1 to 5 cycles until every expected write retired
    task automatic run_with_freezes();
        int burst_left;
        burst_left = 0;
        while (exp_idx < exp_count) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            if (burst_left > 0) begin
                stall_i    = 1'b1;
                burst_left = burst_left - 1;
            end else begin
                stall_i = 1'b0;
                if ($urandom_range(0, 5) == 0) begin
                    burst_left = $urandom_range(1, 5);
                end
            end
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d writes checked, %0d of %0d expected retired, %0d errors",
                 checks, exp_idx, exp_count, errors);
    endtask

    initial begin
        rst_i     = 1'b1;
        stall_i   = 1'b0;
        exp_count = '0;
        void'($urandom(32'h5a4c));
        load_expected();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        run_with_freezes();
        @(posedge clk_i);
        #DRIVE_DELAY;
        stall_i = 1'b0;
        // Program now spins on its final jump, so nothing else may retire
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        print_summary();
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        errors++;
        $display("Watchdog expired after %0d cycles with %0d of %0d expected writes retired",
                 WATCHDOG_CYCLES, exp_idx, exp_count);
        print_summary();
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== rv32i_core.sv ====
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// RV32I five-stage pipelined core
// Connects fetch, decode, execute and memory; retire_o shows each writeback
//--------------------------------------------------------------------------
module rv32i_core
    import rv32i_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    stall_i,
    output retire_t retire_o
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    logic      load_stall;

    rv32i_fetch fetch_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .load_stall_i (load_stall),
        .redirect_i   (redirect),
        .if_id_o      (if_id)
    );

    rv32i_decode decode_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .if_id_i      (if_id),
        .redirect_i   (redirect),
        .wb_i         (retire_o),
        .load_stall_o (load_stall),
        .id_ex_o      (id_ex)
    );

    rv32i_execute execute_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall_i),
        .id_ex_i    (id_ex),
        .wb_i       (retire_o),
        .redirect_o (redirect),
        .ex_mem_o   (ex_mem)
    );

    rv32i_memory memory_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .ex_mem_i (ex_mem),
        .wb_o     (retire_o)
    );

endmodule

// ==== rv32i_memory.sv ====
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// RV32I memory and writeback stage
// Word data array, writeback select and the MEM/WB register
//--------------------------------------------------------------------------
module rv32i_memory
    import rv32i_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    stall_i,
    input  ex_mem_t ex_mem_i,
    output retire_t wb_o
);

    logic [XLEN-1:0]       dmem [DMEM_DEPTH];
    logic [MEM_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       wb_data;

    assign addr = ex_mem_i.alu_result[MEM_ADDR_W+1:2];

    // EX/MEM is held while frozen, so write once on the releasing edge
    always_ff @(posedge clk_i) begin
        if (ex_mem_i.memwrite && !stall_i) begin
            dmem[addr] <= ex_mem_i.store_data;
        end
    end

    assign load_data = ex_mem_i.memread ? dmem[addr] : '0;

    always_comb begin
        case (ex_mem_i.wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_LINK: wb_data = ex_mem_i.link;
            default: wb_data = ex_mem_i.alu_result;
        endcase
    end

    // Bubble while frozen so no writeback repeats
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wb_o <= '0;
        end else if (stall_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= '{we: ex_mem_i.regwrite, rd: ex_mem_i.rd, data: wb_data};
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
                     (ex_mem_i.memread || ex_mem_i.memwrite)
                     |-> ex_mem_i.alu_result[1:0] == 2'b00)
        else $error("memory: misaligned access %h", ex_mem_i.alu_result);

endmodule

// ==== rv32i_execute.sv ====
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// RV32I execute stage
// Operand forwarding, ALU, branch compare, fetch redirect and the EX/MEM
// register
//--------------------------------------------------------------------------
module rv32i_execute
    import rv32i_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      stall_i,
    input  id_ex_t    id_ex_i,
    input  retire_t   wb_i,
    output redirect_t redirect_o,
    output ex_mem_t   ex_mem_o
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            cond;

    // Younger EX/MEM result first; loads there are covered by the interlock
    function automatic logic [XLEN-1:0] forward(
        input logic [REG_ADDR_W-1:0] idx,
        input logic [XLEN-1:0]       reg_data,
        input ex_mem_t               em,
        input retire_t               wb
    );
        logic [XLEN-1:0] result;
        result = reg_data;
        if (idx != '0 && wb.we && wb.rd == idx) begin
            result = wb.data;
        end
        if (idx != '0 && em.regwrite && em.rd == idx && em.wb_sel != WB_MEM) begin
            result = (em.wb_sel == WB_LINK) ? em.link : em.alu_result;
        end
        return result;
    endfunction

    assign src1 = forward(id_ex_i.rs1, id_ex_i.rs1_data, ex_mem_o, wb_i);
    assign src2 = forward(id_ex_i.rs2, id_ex_i.rs2_data, ex_mem_o, wb_i);

    assign op_a = id_ex_i.a_pc  ? id_ex_i.pc : src1;
    assign op_b = id_ex_i.b_reg ? src2 : id_ex_i.imm;

    always_comb begin
        alu_res = '0;
        cond    = 1'b0;
        case (id_ex_i.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_BEQ:  cond = (op_a == op_b);
            ALU_BNE:  cond = (op_a != op_b);
            ALU_BLT:  cond = $signed(op_a) < $signed(op_b);
            ALU_BGE:  cond = $signed(op_a) >= $signed(op_b);
            ALU_BLTU: cond = op_a < op_b;
            ALU_BGEU: cond = op_a >= op_b;
            default:  alu_res = '0;
        endcase
    end

    // Resolved here and taken by fetch in the same cycle
    assign redirect_o.taken  = id_ex_i.valid && (id_ex_i.jal || id_ex_i.jalr || cond);
    assign redirect_o.target = id_ex_i.jalr ? ((src1 + id_ex_i.imm) & ~32'd1)
                                            : (id_ex_i.pc + id_ex_i.imm);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ex_mem_o <= '0;
        end else if (!stall_i) begin
            ex_mem_o.memread    <= id_ex_i.valid && id_ex_i.memread;
            ex_mem_o.memwrite   <= id_ex_i.valid && id_ex_i.memwrite;
            ex_mem_o.regwrite   <= id_ex_i.valid && id_ex_i.regwrite;
            ex_mem_o.wb_sel     <= id_ex_i.wb_sel;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.alu_result <= alu_res;
            ex_mem_o.store_data <= src2;
            ex_mem_o.link       <= id_ex_i.pc + 32'd4;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
                     redirect_o.taken |-> redirect_o.target[1:0] == 2'b00)
        else $error("execute: misaligned target %h", redirect_o.target);

endmodule

// ==== rv32i_decode.sv ====
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// RV32I decode stage
// Register file, field and immediate decode, load-use interlock and the
// ID/EX register
//--------------------------------------------------------------------------
module rv32i_decode
    import rv32i_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      stall_i,
    input  if_id_t    if_id_i,
    input  redirect_t redirect_i,
    input  retire_t   wb_i,
    output logic      load_stall_o,
    output id_ex_t    id_ex_o
);

    logic [XLEN-1:0]       regs [32];
    logic [XLEN-1:0]       instr;
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic                  known;
    logic                  writes_rd;
    logic                  alt;
    alu_op_e               alu_op;
    id_ex_t                id_ex_d;

    assign instr  = if_id_i.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];

    assign known = opcode inside {OP_R, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH,
                                  OP_JAL, OP_JALR, OP_LUI, OP_AUIPC};
    assign writes_rd = (rd != '0) && (opcode inside {OP_R, OP_IMM, OP_LOAD,
                                                     OP_JAL, OP_JALR, OP_LUI, OP_AUIPC});

    // Unused source fields read as x0 so they never forward or interlock
    assign rs1 = (opcode inside {OP_LUI, OP_AUIPC, OP_JAL}) ? '0 : instr[19:15];
    assign rs2 = (opcode inside {OP_R, OP_BRANCH, OP_STORE}) ? instr[24:20] : '0;

    always_ff @(posedge clk_i) begin
        if (wb_i.we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Write-first read
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb_i.we && wb_i.rd == rs1) ? wb_i.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb_i.we && wb_i.rd == rs2) ? wb_i.data : regs[rs2];

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC:  imm = {instr[31:12], 12'b0};
            OP_JAL:            imm = {{12{instr[31]}}, instr[19:12], instr[20],
                                      instr[30:21], 1'b0};
            OP_BRANCH:         imm = {{20{instr[31]}}, instr[7], instr[30:25],
                                      instr[11:8], 1'b0};
            OP_STORE:          imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_LOAD, OP_JALR:  imm = {{20{instr[31]}}, instr[31:20]};
            OP_IMM:            imm = (funct3[1:0] == 2'b01) ? {27'b0, instr[24:20]}
                                                            : {{20{instr[31]}}, instr[31:20]};
            default:           imm = '0;
        endcase
    end

    // Bit 30 picks sub and sra; for immediates only the shift uses it
    assign alt = instr[30] && (opcode == OP_R || funct3 == 3'b101);

    always_comb begin
        if (opcode == OP_BRANCH) begin
            case (funct3)
                3'b001:  alu_op = ALU_BNE;
                3'b100:  alu_op = ALU_BLT;
                3'b101:  alu_op = ALU_BGE;
                3'b110:  alu_op = ALU_BLTU;
                3'b111:  alu_op = ALU_BGEU;
                default: alu_op = ALU_BEQ;
            endcase
        end else if (opcode == OP_R || opcode == OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = alt ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else begin
            alu_op = ALU_ADD;
        end
    end

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = known;
        id_ex_d.jal      = (opcode == OP_JAL);
        id_ex_d.jalr     = (opcode == OP_JALR);
        id_ex_d.a_pc     = (opcode == OP_AUIPC);
        id_ex_d.b_reg    = (opcode == OP_R) || (opcode == OP_BRANCH);
        id_ex_d.alu_op   = alu_op;
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm;
        id_ex_d.memread  = (opcode == OP_LOAD);
        id_ex_d.memwrite = (opcode == OP_STORE);
        id_ex_d.wb_sel   = (opcode == OP_LOAD) ? WB_MEM :
                           (opcode inside {OP_JAL, OP_JALR}) ? WB_LINK : WB_ALU;
        id_ex_d.regwrite = writes_rd;
        id_ex_d.rd       = writes_rd ? rd : '0;
        id_ex_d.pc       = if_id_i.pc;
    end

    assign load_stall_o = id_ex_o.valid && id_ex_o.memread && id_ex_o.rd != '0 &&
                          (id_ex_o.rd == rs1 || id_ex_o.rd == rs2);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            id_ex_o <= '0;
        end else if (stall_i) begin
            // MEM/WB drains during a freeze, so the held operands take its write
            if (wb_i.we && wb_i.rd == id_ex_o.rs1) begin
                id_ex_o.rs1_data <= wb_i.data;
            end
            if (wb_i.we && wb_i.rd == id_ex_o.rs2) begin
                id_ex_o.rs2_data <= wb_i.data;
            end
        end else if (redirect_i.taken || load_stall_o) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
                     id_ex_o.valid |-> !$isunknown(id_ex_o.rd))
        else $error("decode: valid ID/EX entry with unknown rd");

endmodule

// ==== rv32i_fetch.sv ====
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// RV32I fetch stage
// Program counter, instruction array and the IF/ID register
//--------------------------------------------------------------------------
module rv32i_fetch
    import rv32i_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      stall_i,
    input  logic      load_stall_i,
    input  redirect_t redirect_i,
    output if_id_t    if_id_o
);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;

    initial begin
        $readmemh(IMEM_FILE, imem);
    end

    assign instr = imem[pc[MEM_ADDR_W+1:2]];

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc      <= RESET_PC;
            if_id_o <= '{pc: RESET_PC, instr: NOP_INSTR};
        end else if (!stall_i) begin
            // Redirect wins over the load-use hold
            if (redirect_i.taken) begin
                pc      <= redirect_i.target;
                if_id_o <= '{pc: pc, instr: NOP_INSTR};
            end else if (!load_stall_i) begin
                pc      <= pc + 32'd4;
                if_id_o <= '{pc: pc, instr: instr};
            end
        end
    end

    // Holds across redirects from execute as well as sequential steps
    assert property (@(posedge clk_i) disable iff (rst_i) pc[1:0] == 2'b00)
        else $error("fetch: misaligned pc %h", pc);

endmodule

// ==== rv32i_pkg.sv ====
//--------------------------------------------------------------------------
// RV32I core package
// Sizes, opcode and ALU encodings and the records carried between the
// five pipeline stages
//--------------------------------------------------------------------------
package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int MEM_ADDR_W = 8;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;
    localparam string IMEM_FILE = "program.hex";

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    // Arithmetic codes first, branch compares in the upper six
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic                  jal;
        logic                  jalr;
        logic                  a_pc;
        logic                  b_reg;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic                  memread;
        logic                  memwrite;
        wb_sel_e               wb_sel;
        logic                  regwrite;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc;
    } id_ex_t;

    typedef struct packed {
        logic                  memread;
        logic                  memwrite;
        logic                  regwrite;
        wb_sel_e               wb_sel;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       link;
    } ex_mem_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage
